/* Makefile */
VERILATOR := verilator
TOP       := tb_icache
RTL_TOP   := icache_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulation is the result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+.
icache_pkg.sv
icache_way.sv
way_select.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

/* icache_consts.svh */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch path widths
`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32

// geometry
`define ICACHE_LINE_WORDS  4
`define ICACHE_SETS        64
`define ICACHE_WAYS        2   // 4 also works

// request queue depth, equal to the credits handed out after reset
`define ICACHE_CREDITS     2

// derived field widths
`define ICACHE_BYTE_W      2
`define ICACHE_OFFSET_W    $clog2(`ICACHE_LINE_WORDS)
`define ICACHE_INDEX_W     $clog2(`ICACHE_SETS)
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - `ICACHE_OFFSET_W - `ICACHE_INDEX_W - `ICACHE_BYTE_W)
`define ICACHE_WAY_W       $clog2(`ICACHE_WAYS)

`endif

/* icache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "icache_consts.svh"

module icache_ctrl
	import icache_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,
	input  fetch_req_t                   req,
	output logic                         credit,
	output fetch_rsp_t                   rsp,
	output mem_req_t                     mem_req,
	input  logic                         mem_ready,
	input  logic                         mem_rvalid,
	input  logic [`ICACHE_WORD_W-1:0]    mem_rdata,
	output logic [`ICACHE_INDEX_W-1:0]   lookup_index,
	output logic [`ICACHE_TAG_W-1:0]     lookup_tag,
	output logic [`ICACHE_OFFSET_W-1:0]  lookup_offset,
	output logic [`ICACHE_WAYS-1:0]      fill_we,
	output line_t                        fill_line,
	output logic [`ICACHE_TAG_W-1:0]     fill_tag,
	output logic                         touch,
	output logic [`ICACHE_WAY_W-1:0]     touch_way,
	input  logic                         hit,
	input  logic [`ICACHE_WORD_W-1:0]    hit_word,
	input  logic [`ICACHE_WAY_W-1:0]     victim_way
);

	localparam int CREDITS  = `ICACHE_CREDITS;
	localparam int CNT_W    = $clog2(CREDITS + 1);
	localparam int PTR_W    = (CREDITS > 1) ? $clog2(CREDITS) : 1;
	localparam int OFF_W    = `ICACHE_OFFSET_W;
	localparam int LINE_LSB = `ICACHE_OFFSET_W + `ICACHE_BYTE_W;

	localparam logic [2:0] S_IDLE     = 3'd0;
	localparam logic [2:0] S_LOOKUP   = 3'd1;
	localparam logic [2:0] S_REFILL   = 3'd2;
	localparam logic [2:0] S_FILL     = 3'd3;
	localparam logic [2:0] S_RELOOKUP = 3'd4;

	logic [2:0]                 state_q, state_d;
	fetch_addr_u                q_mem [CREDITS];
	logic [PTR_W-1:0]           q_wr, q_rd;
	logic [CNT_W-1:0]           q_count;
	logic [CNT_W-1:0]           init_cnt;
	fetch_addr_u                head;
	logic                       lookup_active, pop, last_beat, fill_go;
	logic                       rsp_valid, mem_req_valid;
	logic [`ICACHE_WORD_W-1:0]  rsp_data;
	logic [OFF_W-1:0]           beat_cnt;
	line_t                      line_q;
	logic [`ICACHE_WAY_W-1:0]   victim_q;

	assign head          = q_mem[q_rd];   // oldest pending request
	assign lookup_index  = head.fields.index;
	assign lookup_tag    = head.fields.tag;
	assign lookup_offset = head.fields.offset;

	assign lookup_active = (state_q == S_LOOKUP) || (state_q == S_RELOOKUP);
	assign pop           = lookup_active && hit;
	assign last_beat     = (state_q == S_REFILL) && mem_rvalid &&
	                       (beat_cnt == OFF_W'(`ICACHE_LINE_WORDS - 1));
	assign fill_go       = (state_q == S_FILL) && !flush;   // flush holds the write off

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: if (req.valid || q_count != '0) state_d = S_LOOKUP;
			S_LOOKUP, S_RELOOKUP: begin
				if (!hit)
					state_d = S_REFILL;
				else if (q_count > CNT_W'(1) || req.valid)
					state_d = S_LOOKUP;
				else
					state_d = S_IDLE;
			end
			S_REFILL: if (last_beat) state_d = S_FILL;
			S_FILL:   if (!flush) state_d = S_RELOOKUP;
			default:  state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q       <= S_IDLE;
			q_wr          <= '0;
			q_rd          <= '0;
			q_count       <= '0;
			init_cnt      <= '0;
			credit        <= 1'b0;
			rsp_valid     <= 1'b0;
			mem_req_valid <= 1'b0;
			beat_cnt      <= '0;
		end else begin
			state_q <= state_d;
			if (req.valid)
				q_wr <= (q_wr == PTR_W'(CREDITS - 1)) ? '0 : q_wr + 1'b1;
			if (pop)
				q_rd <= (q_rd == PTR_W'(CREDITS - 1)) ? '0 : q_rd + 1'b1;
			case ({req.valid, pop})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
			// initial credits, one per cycle, returns take the slot first
			credit <= pop || (init_cnt != CNT_W'(CREDITS));
			if (!pop && init_cnt != CNT_W'(CREDITS))
				init_cnt <= init_cnt + 1'b1;
			rsp_valid <= pop;
			if (lookup_active && !hit)
				mem_req_valid <= 1'b1;
			else if (mem_req_valid && mem_ready)
				mem_req_valid <= 1'b0;
			if (state_q == S_REFILL && mem_rvalid)
				beat_cnt <= beat_cnt + 1'b1;   // wraps to 0 after last beat
		end
	end

	always_ff @(posedge clk) begin
		if (req.valid)
			q_mem[q_wr] <= req.addr;
		if (pop)
			rsp_data <= hit_word;
		if (lookup_active && !hit)
			victim_q <= victim_way;   // way picked at miss time
		if (state_q == S_REFILL && mem_rvalid)
			line_q[beat_cnt] <= mem_rdata;
	end

	assign rsp.valid     = rsp_valid;
	assign rsp.data      = rsp_data;
	assign mem_req.valid = mem_req_valid;
	assign mem_req.addr  = {head.raw[`ICACHE_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};

	always_comb begin
		fill_we = '0;
		if (fill_go)
			fill_we[victim_q] = 1'b1;
	end

	assign fill_line = line_q;
	assign fill_tag  = head.fields.tag;
	assign touch     = pop || fill_go;
	assign touch_way = victim_q;   // way_select uses its own hit way on hits

	// responses only come from lookups, never while a line is in flight
	a_no_rsp_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
		state_q == S_REFILL |-> !rsp_valid);

	// requester must stay within its credits
	a_queue_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		(req.valid && q_count == CNT_W'(CREDITS)) |-> pop);

endmodule

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

	// lookup view of a fetch address
	typedef struct packed {
		logic [`ICACHE_TAG_W-1:0]    tag;
		logic [`ICACHE_INDEX_W-1:0]  index;
		logic [`ICACHE_OFFSET_W-1:0] offset;   // word within line
		logic [`ICACHE_BYTE_W-1:0]   byte_off;
	} fetch_fields_t;

	// same word seen raw (memory side) or split (tag compare)
	typedef union packed {
		logic [`ICACHE_ADDR_W-1:0] raw;
		fetch_fields_t             fields;
	} fetch_addr_u;

	typedef struct packed {
		logic        valid;
		fetch_addr_u addr;
	} fetch_req_t;

	typedef struct packed {
		logic                      valid;
		logic [`ICACHE_WORD_W-1:0] data;
	} fetch_rsp_t;

	typedef struct packed {
		logic                      valid;
		logic [`ICACHE_ADDR_W-1:0] addr;   // line aligned
	} mem_req_t;

	typedef struct packed {
		logic                      hit;
		logic                      valid;
		logic [`ICACHE_WORD_W-1:0] word;
	} way_result_t;

	typedef logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0] line_t;

endpackage

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "icache_consts.svh"

module icache_top
	import icache_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       flush,
	input  fetch_req_t                 req,
	output logic                       credit,
	output fetch_rsp_t                 rsp,
	output mem_req_t                   mem_req,
	input  logic                       mem_ready,
	input  logic                       mem_rvalid,
	input  logic [`ICACHE_WORD_W-1:0]  mem_rdata
);

	logic [`ICACHE_INDEX_W-1:0]        lookup_index;
	logic [`ICACHE_TAG_W-1:0]          lookup_tag;
	logic [`ICACHE_OFFSET_W-1:0]       lookup_offset;
	logic [`ICACHE_WAYS-1:0]           fill_we;
	line_t                             fill_line;
	logic [`ICACHE_TAG_W-1:0]          fill_tag;
	logic                              touch;
	logic [`ICACHE_WAY_W-1:0]          touch_way;
	logic                              hit;
	logic [`ICACHE_WORD_W-1:0]         hit_word;
	logic [`ICACHE_WAY_W-1:0]          victim_way;
	way_result_t [`ICACHE_WAYS-1:0]    results;

	icache_ctrl u_ctrl (
		.clk, .rst_n, .flush, .req, .credit, .rsp,
		.mem_req, .mem_ready, .mem_rvalid, .mem_rdata,
		.lookup_index, .lookup_tag, .lookup_offset,
		.fill_we, .fill_line, .fill_tag,
		.touch, .touch_way,
		.hit, .hit_word, .victim_way
	);

	for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
		icache_way u_way (
			.clk, .rst_n, .flush,
			.lookup_index, .lookup_tag, .lookup_offset,
			.fill_we  (fill_we[g]),
			.fill_line, .fill_tag,
			.result   (results[g])
		);
	end

	way_select u_sel (
		.clk, .rst_n, .flush, .lookup_index, .results,
		.touch, .touch_way,
		.hit, .hit_way (), .hit_word, .victim_way   // hit way only feeds the LRU update
	);

endmodule

`default_nettype wire

/* icache_way.sv */
`timescale 1ns/10ps
`default_nettype none

`include "icache_consts.svh"

module icache_way
	import icache_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush,
	input  logic [`ICACHE_INDEX_W-1:0]   lookup_index,
	input  logic [`ICACHE_TAG_W-1:0]     lookup_tag,
	input  logic [`ICACHE_OFFSET_W-1:0]  lookup_offset,
	input  logic                         fill_we,
	input  line_t                        fill_line,
	input  logic [`ICACHE_TAG_W-1:0]     fill_tag,
	output way_result_t                  result
);

	logic [`ICACHE_SETS-1:0]   valid_q;
	logic [`ICACHE_TAG_W-1:0]  tag_q  [`ICACHE_SETS];
	line_t                     data_q [`ICACHE_SETS];

	// valid bits, flush beats a fill
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (flush) begin
			valid_q <= '0;
		end else if (fill_we) begin
			valid_q[lookup_index] <= 1'b1;
		end
	end

	// whole line and tag written in one go
	always_ff @(posedge clk) begin
		if (fill_we) begin
			tag_q[lookup_index]  <= fill_tag;
			data_q[lookup_index] <= fill_line;
		end
	end

	always_comb begin
		result.valid = valid_q[lookup_index];
		result.hit   = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
		result.word  = data_q[lookup_index][lookup_offset];
	end

	// controller must hold its fill while a flush is on
	a_no_fill_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
		!(fill_we && flush));

endmodule

`default_nettype wire

/* tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

`include "icache_consts.svh"

module tb_icache
	import icache_pkg::*;
();

	localparam int CREDITS    = `ICACHE_CREDITS;
	localparam int NUM        = 16;
	localparam int WAIT_LIMIT = 200;

	typedef struct packed {
		logic [31:0] addr;
		logic        miss;    // refill expected
		logic        flush;   // flush before sending
		logic        solo;    // sent with nothing outstanding
	} stim_t;

	logic                       clk;
	logic                       rst_n;
	logic                       flush;
	fetch_req_t                 req;
	logic                       credit;
	fetch_rsp_t                 rsp;
	mem_req_t                   mem_req;
	logic                       mem_ready;
	logic                       mem_rvalid;
	logic [`ICACHE_WORD_W-1:0]  mem_rdata;
	int                         mem_count;
	logic [`ICACHE_ADDR_W-1:0]  mem_addr;

	stim_t stim [NUM];
	int    exp_q [$];   // entries awaiting a response in issue order
	int    issue_cycle [NUM];
	logic  lat_check [NUM];
	int    cycle, credits, outstanding, exp_misses;

	icache_top DUT (
		.clk, .rst_n, .flush, .req, .credit, .rsp,
		.mem_req, .mem_ready, .mem_rvalid, .mem_rdata
	);

	tb_mem_model u_mem (
		.clk, .rst_n, .mem_req, .mem_ready, .mem_rvalid, .mem_rdata,
		.req_count (mem_count),
		.last_addr (mem_addr)
	);

	always #4 clk = ~clk;

	// word address xor pattern plus word index within the line
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		logic [31:0] waddr;
		waddr = {addr[31:2], 2'b00};
		return (waddr ^ 32'h5a5a_0000) + 32'(addr[3:2]);
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_response();
		int          e;
		logic [31:0] addr;
		assert (exp_q.size() > 0) else stop_on_error("a response came with no request outstanding");
		e = exp_q.pop_front();
		addr = stim[e].addr;
		outstanding--;
		exp_misses += stim[e].miss;
		assert (rsp.data == expected_word(addr))
			else stop_on_error($sformatf("error rsp.data entry %0d got %h expected %h",
				e, rsp.data, expected_word(addr)));
		assert (mem_count == exp_misses)
			else stop_on_error($sformatf("error mem_req count entry %0d got %h expected %h",
				e, mem_count, exp_misses));
		if (stim[e].miss) begin
			assert (mem_addr == {addr[31:4], 4'h0})
				else stop_on_error($sformatf("error mem_req.addr entry %0d got %h expected %h",
					e, mem_addr, {addr[31:4], 4'h0}));
		end
		if (lat_check[e]) begin
			assert (cycle - issue_cycle[e] == 2)
				else stop_on_error($sformatf("error rsp.valid latency entry %0d got %h expected %h",
					e, cycle - issue_cycle[e], 2));
		end
	endtask

	// one clock then sample at +1 ns and release the inputs
	task automatic step();
		@(posedge clk);
		#1;
		cycle++;
		if (credit)
			credits++;
		if (rsp.valid)
			check_response();
		assert (credits + outstanding <= CREDITS)
			else stop_on_error("more credits and requests in flight than the queue can hold");
		req   = '0;
		flush = 1'b0;
	endtask

	task automatic wait_credit();
		int t;
		t = 0;
		while (credits == 0 && t < WAIT_LIMIT) begin
			step();
			t++;
		end
		assert (credits > 0) else stop_on_error("timeout while waiting for a credit");
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while (outstanding > 0 && t < WAIT_LIMIT) begin
			step();
			t++;
		end
		assert (outstanding == 0) else stop_on_error("timeout while waiting for responses");
	endtask

	task automatic send_request(input int e);
		req.valid      = 1'b1;
		req.addr.raw   = stim[e].addr;
		credits--;
		lat_check[e]   = stim[e].solo && !stim[e].miss;
		issue_cycle[e] = cycle;
		outstanding++;
		exp_q.push_back(e);
		step();
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		flush       = 1'b0;
		req         = '0;
		cycle       = 0;
		credits     = 0;
		outstanding = 0;
		exp_misses  = 0;
		// set 5 holds tags A 0x40, B 0x80, C 0xc0
		stim = '{
			'{32'h0000_1230, 1'b1, 1'b0, 1'b1},   // cold miss
			'{32'h0000_1238, 1'b0, 1'b0, 1'b1},   // idle hit on the same line
			'{32'h0000_123c, 1'b0, 1'b0, 1'b0},
			'{32'h0001_0054, 1'b1, 1'b0, 1'b1},   // A
			'{32'h0002_0058, 1'b1, 1'b0, 1'b0},   // B queued behind A
			'{32'h0001_005c, 1'b0, 1'b0, 1'b0},   // A
			'{32'h0003_0050, 1'b1, 1'b0, 1'b0},   // C replaces B
			'{32'h0001_0050, 1'b0, 1'b0, 1'b0},   // A still resident
			'{32'h0002_005c, 1'b1, 1'b0, 1'b0},   // B back and evicts C
			'{32'h0000_4560, 1'b1, 1'b0, 1'b0},
			'{32'h0000_4564, 1'b0, 1'b0, 1'b0},   // waits on its own refill
			'{32'h0000_1234, 1'b0, 1'b0, 1'b0},
			'{32'h0000_1238, 1'b1, 1'b1, 1'b0},   // misses again after flush
			'{32'h0000_1230, 1'b0, 1'b0, 1'b1},
			'{32'h0001_0050, 1'b1, 1'b0, 1'b0},
			'{32'h0001_005c, 1'b0, 1'b0, 1'b0}
		};
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < NUM; i++) begin
			if (stim[i].flush || stim[i].solo)
				wait_drained();
			if (stim[i].flush) begin
				flush = 1'b1;
				step();
			end
			wait_credit();
			send_request(i);
		end
		wait_drained();
		repeat (4) step();   // nothing stray after the last response
		assert (credits == CREDITS)
			else stop_on_error($sformatf("error credits got %h expected %h", credits, CREDITS));
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

`include "icache_consts.svh"

module tb_mem_model
	import icache_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  mem_req_t                   mem_req,
	output logic                       mem_ready,
	output logic                       mem_rvalid,
	output logic [`ICACHE_WORD_W-1:0]  mem_rdata,
	output int                         req_count,
	output logic [`ICACHE_ADDR_W-1:0]  last_addr
);

	integer seed = 32'h67c5;

	// one line at a time, random idle gaps before ready and between beats
	initial begin
		int                        gap;
		logic [`ICACHE_ADDR_W-1:0] line_addr;
		mem_ready  = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata  = '0;
		req_count  = 0;
		last_addr  = '0;
		forever begin
			@(posedge clk);
			#1;
			if (rst_n && mem_req.valid) begin
				line_addr = mem_req.addr;
				gap = $unsigned($random(seed)) % 3;
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
				mem_ready = 1'b1;   // taken at the next edge
				req_count = req_count + 1;
				last_addr = line_addr;
				@(posedge clk);
				#1;
				mem_ready = 1'b0;
				for (int beat = 0; beat < `ICACHE_LINE_WORDS; beat++) begin
					gap = $unsigned($random(seed)) % 3;
					repeat (gap) begin
						@(posedge clk);
						#1;
					end
					mem_rvalid = 1'b1;
					mem_rdata  = ((line_addr + 4 * beat) ^ 32'h5a5a_0000) + beat;
					@(posedge clk);
					#1;
					mem_rvalid = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* way_select.sv */
`timescale 1ns/10ps
`default_nettype none

`include "icache_consts.svh"

module way_select
	import icache_pkg::*;
(
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                flush,
	input  logic [`ICACHE_INDEX_W-1:0]          lookup_index,
	input  way_result_t [`ICACHE_WAYS-1:0]      results,
	input  logic                                touch,
	input  logic [`ICACHE_WAY_W-1:0]            touch_way,
	output logic                                hit,
	output logic [`ICACHE_WAY_W-1:0]            hit_way,
	output logic [`ICACHE_WORD_W-1:0]           hit_word,
	output logic [`ICACHE_WAY_W-1:0]            victim_way
);

	localparam int WAYS  = `ICACHE_WAYS;
	localparam int WAY_W = `ICACHE_WAY_W;

	logic [`ICACHE_SETS-1:0][WAY_W-1:0] lru_q;   // way to replace next, per set
	logic [WAYS-1:0]                    hits;
	logic [WAY_W-1:0]                   upd_way;

	always_comb begin
		hit      = 1'b0;
		hit_way  = '0;
		hit_word = '0;
		for (int w = 0; w < WAYS; w++) begin
			hits[w] = results[w].hit;
			if (results[w].hit) begin
				hit      = 1'b1;
				hit_way  = WAY_W'(w);
				hit_word = results[w].word;
			end
		end
	end

	// lowest free way, else the LRU one
	always_comb begin
		victim_way = lru_q[lookup_index];
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!results[w].valid)
				victim_way = WAY_W'(w);
		end
	end

	assign upd_way = hit ? hit_way : touch_way;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lru_q <= '0;
		end else if (flush) begin
			lru_q <= '0;
		end else if (touch) begin
			// point past the used way, for two ways that is the other one
			lru_q[lookup_index] <= (upd_way == WAY_W'(WAYS - 1)) ? '0 : upd_way + 1'b1;
		end
	end

	// tag arrays must never hold one line twice in a set
	a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(hits));

endmodule

`default_nettype wire
